/* common/boxcar_cfg.svh */
`ifndef BOXCAR_CFG_SVH
`define BOXCAR_CFG_SVH

// number of lanes in the bank, one per channel
`define BOX_CHANNELS 4

// samples held in each moving sum
`define BOX_WINDOW 8

// raw sample width
`define BOX_SAMPLE_W 12

// sum needs log2(window) bits of headroom over a sample
`define BOX_SUM_W (`BOX_SAMPLE_W + $clog2(`BOX_WINDOW))

// channel tag width
`define BOX_CHAN_W ($clog2(`BOX_CHANNELS))

`endif

/* common/boxcar_pkg.sv */
`include "boxcar_cfg.svh"

package boxcar_pkg;

  // unsigned input sample
  typedef logic [`BOX_SAMPLE_W-1:0] sample_t;

  // running sum, wide enough for a full window of max samples
  typedef logic [`BOX_SUM_W-1:0] sum_t;

  // channel number tag on the stream
  typedef logic [`BOX_CHAN_W-1:0] chan_t;

endpackage

/* common/lane_if.sv */
`timescale 1ns/1ps

interface lane_if import boxcar_pkg::*; ();

  // distributor to lane
  logic    sample_stb;
  sample_t sample;

  // lane to collector
  logic    sum_stb;
  sum_t    sum;

  // distributor side
  modport feed (
    output sample_stb,
    output sample
  );

  // running-sum engine
  modport lane (
    input  sample_stb,
    input  sample,
    output sum_stb,
    output sum
  );

  // collector side
  modport drain (
    input  sum_stb,
    input  sum
  );

endinterface

/* boxcar/shift_reg.sv */
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// enable-only delay line, DEPTH+1 stages
////////////////////////////////////////////////////////////////////////////

module shift_reg #(
  parameter int WIDTH = 1,
  parameter int DEPTH = 7
) (
  input  logic             clk,
  input  logic             ena,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout
);

  // stage 0 takes din, stage DEPTH drives dout
  logic [WIDTH-1:0] stage [DEPTH+1];

  // no reset here so the tools can map the chain onto SRL LUTs
  // contents are don't-care until the owner has filled it
  always_ff @(posedge clk) begin
    if (ena) begin
      stage[0] <= din;
      // move everything one place down the chain
      for (int i = 1; i <= DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  // last stage, read just before a shift gives the sample
  // that entered DEPTH+1 shifts ago
  assign dout = stage[DEPTH];

endmodule

/* boxcar/boxcar_lane.sv */
`timescale 1ns/1ps
`include "boxcar_cfg.svh"

////////////////////////////////////////////////////////////////////////////
// one channel of the moving-sum bank
////////////////////////////////////////////////////////////////////////////

module boxcar_lane import boxcar_pkg::*; (
  input logic  clk,
  input logic  reset,
  lane_if.lane lane
);

  // counts 0..BOX_WINDOW, so one extra code is needed
  localparam int FILL_W = $clog2(`BOX_WINDOW + 1);

  logic [FILL_W-1:0] fill_cnt;
  logic              window_full;
  sample_t           leaving;
  sample_t           subtrahend;
  sum_t              sum_q;
  sum_t              sum_next;
  logic              sum_stb_q;

  // window-1 extra stages, dout is the sample BOX_WINDOW shifts old
  shift_reg #(
    .WIDTH (`BOX_SAMPLE_W),
    .DEPTH (`BOX_WINDOW - 1)
  ) i_delay (
    .clk  (clk),
    .ena  (lane.sample_stb),
    .din  (lane.sample),
    .dout (leaving)
  );

  // delay line output only valid once a whole window went in
  assign window_full = (fill_cnt == FILL_W'(`BOX_WINDOW));
  assign subtrahend  = window_full ? leaving : '0;

  // add newest, drop oldest
  // wraps mid-expression but the final value always fits
  assign sum_next = sum_q + sum_t'(lane.sample) - sum_t'(subtrahend);

  always_ff @(posedge clk) begin
    if (reset) begin
      fill_cnt  <= '0;
      sum_q     <= '0;
      sum_stb_q <= 1'b0;
    end else begin
      // one-cycle result pulse per input sample
      sum_stb_q <= lane.sample_stb;
      if (lane.sample_stb) begin
        sum_q <= sum_next;
        // saturate once the window is full
        if (!window_full) begin
          fill_cnt <= fill_cnt + 1'b1;
        end
      end
    end
  end

  assign lane.sum_stb = sum_stb_q;
  assign lane.sum     = sum_q;

endmodule

/* verilog/lane_distributor.sv */
`timescale 1ns/1ps
`include "boxcar_cfg.svh"

////////////////////////////////////////////////////////////////////////////
// channel decode, input stream to per-lane strobes
////////////////////////////////////////////////////////////////////////////

module lane_distributor import boxcar_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    in_stb,
  input  chan_t   in_chan,
  input  sample_t in_sample,
  lane_if.feed    lanes [`BOX_CHANNELS]
);

  logic [`BOX_CHANNELS-1:0] hit;
  logic [`BOX_CHANNELS-1:0] stb_q;
  sample_t                  sample_q;

  // one-hot decode
  // tags >= BOX_CHANNELS match nothing and are dropped
  always_comb begin
    for (int i = 0; i < `BOX_CHANNELS; i++) begin
      hit[i] = in_stb && (in_chan == chan_t'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stb_q <= '0;
    end else begin
      stb_q <= hit;
    end
  end

  // shared sample register, only the strobed lane uses it
  always_ff @(posedge clk) begin
    if (in_stb) begin
      sample_q <= in_sample;
    end
  end

  // fan out to every lane
  for (genvar g = 0; g < `BOX_CHANNELS; g++) begin : feed_gen
    assign lanes[g].sample_stb = stb_q[g];
    assign lanes[g].sample     = sample_q;
  end

endmodule

/* verilog/lane_collector.sv */
`timescale 1ns/1ps
`include "boxcar_cfg.svh"

////////////////////////////////////////////////////////////////////////////
// merge lane results into one tagged output stream
////////////////////////////////////////////////////////////////////////////

module lane_collector import boxcar_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  lane_if.drain lanes [`BOX_CHANNELS],
  output logic  out_stb,
  output chan_t out_chan,
  output sum_t  out_sum
);

  logic [`BOX_CHANNELS-1:0] stb_vec;
  sum_t                     sum_arr [`BOX_CHANNELS];
  logic                     hit;
  chan_t                    sel_chan;
  sum_t                     sel_sum;

  // flatten the interface array so it can be scanned with a loop index
  for (genvar g = 0; g < `BOX_CHANNELS; g++) begin : drain_gen
    assign stb_vec[g] = lanes[g].sum_stb;
    assign sum_arr[g] = lanes[g].sum;
  end

  // at most one lane strobes per cycle, so no priority is needed
  always_comb begin
    hit      = 1'b0;
    sel_chan = '0;
    sel_sum  = '0;
    for (int i = 0; i < `BOX_CHANNELS; i++) begin
      if (stb_vec[i]) begin
        hit      = 1'b1;
        sel_chan = chan_t'(i);
        sel_sum  = sum_arr[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_stb <= 1'b0;
    end else begin
      out_stb <= hit;
    end
  end

  // tag and sum hold their last value while idle
  always_ff @(posedge clk) begin
    if (hit) begin
      out_chan <= sel_chan;
      out_sum  <= sel_sum;
    end
  end

endmodule

/* verilog/boxcar_bank.sv */
`timescale 1ns/1ps
`include "boxcar_cfg.svh"

////////////////////////////////////////////////////////////////////////////
// multi-channel boxcar filter bank, top level
////////////////////////////////////////////////////////////////////////////

module boxcar_bank import boxcar_pkg::*; (
  input  logic    clk,
  input  logic    reset,

  // tagged input stream, one sample per strobe
  input  logic    in_stb,
  input  chan_t   in_chan,
  input  sample_t in_sample,

  // tagged sums, three cycles after the input
  output logic    out_stb,
  output chan_t   out_chan,
  output sum_t    out_sum
);

  // one link per channel
  lane_if lanes [`BOX_CHANNELS] ();

  // stage 1, decode and register
  lane_distributor i_dist (
    .clk       (clk),
    .reset     (reset),
    .in_stb    (in_stb),
    .in_chan   (in_chan),
    .in_sample (in_sample),
    .lanes     (lanes)
  );

  // stage 2, running sums
  for (genvar g = 0; g < `BOX_CHANNELS; g++) begin : lane_gen
    boxcar_lane i_lane (
      .clk   (clk),
      .reset (reset),
      .lane  (lanes[g])
    );
  end

  // stage 3, merge and tag
  lane_collector i_coll (
    .clk      (clk),
    .reset    (reset),
    .lanes    (lanes),
    .out_stb  (out_stb),
    .out_chan (out_chan),
    .out_sum  (out_sum)
  );

endmodule

/* test/tb_boxcar_bank.sv */
`timescale 1ns/1ps
`include "boxcar_cfg.svh"

module tb_boxcar_bank import boxcar_pkg::*; ;

  // one stimulus step plus the sum the model expects for it
  typedef struct packed {
    logic    stb;
    chan_t   chan;
    sample_t sample;
    sum_t    exp_sum;
  } row_t;

  // pending output, due at a fixed cycle
  typedef struct packed {
    chan_t chan;
    sum_t  sum;
    int    due;
  } exp_t;

  logic    clk = 1'b0;
  logic    reset = 1'b1;
  logic    in_stb = 1'b0;
  chan_t   in_chan = '0;
  sample_t in_sample = '0;
  logic    out_stb;
  chan_t   out_chan;
  sum_t    out_sum;

  int      seed = 32'ha8e5_6264;
  int      cyc = 0;
  int      err_cnt = 0;
  int      chk_cnt = 0;
  int      test_cnt = 0;
  int      err_base = 0;
  row_t    tbl [$];
  exp_t    exp_q [$];
  sample_t hist [`BOX_CHANNELS][$];

  boxcar_bank i_dut (
    .clk       (clk),
    .reset     (reset),
    .in_stb    (in_stb),
    .in_chan   (in_chan),
    .in_sample (in_sample),
    .out_stb   (out_stb),
    .out_chan  (out_chan),
    .out_sum   (out_sum)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // nonblocking, so the driver sees the pre-edge count
  always @(posedge clk) cyc <= cyc + 1;

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_sum(string name, sum_t exp, sum_t act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("ERR %0t %s exp=%0d act=%0d", $time, name, exp, act);
    end
  endtask

  task automatic check_chan(string name, chan_t exp, chan_t act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("ERR %0t %s exp=%0d act=%0d", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("ERR %0t %s exp=%b act=%b", $time, name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // sum of the channel's last up-to-window samples
  function automatic sum_t model_push(chan_t ch, sample_t s);
    int acc;
    acc = 0;
    hist[ch].push_back(s);
    if (hist[ch].size() > `BOX_WINDOW) begin
      void'(hist[ch].pop_front());
    end
    for (int k = 0; k < hist[ch].size(); k++) begin
      acc += hist[ch][k];
    end
    // a sum_t that is too narrow would silently wrap here
    if (acc >= (1 << `BOX_SUM_W)) begin
      err_cnt++;
      $display("reference sum %0d does not fit in sum_t", acc);
    end
    return sum_t'(acc);
  endfunction

  function automatic void model_clear();
    for (int i = 0; i < `BOX_CHANNELS; i++) begin
      hist[i].delete();
    end
  endfunction

  task automatic add_row(logic stb, chan_t ch, sample_t s);
    row_t r;
    r.stb     = stb;
    r.chan    = ch;
    r.sample  = s;
    r.exp_sum = '0;
    // out-of-range tags are dropped by the DUT
    if (stb && (ch < `BOX_CHANNELS)) begin
      r.exp_sum = model_push(ch, s);
    end
    tbl.push_back(r);
  endtask

  function automatic chan_t rand_chan();
    int r;
    r = $random(seed);
    return chan_t'((r & 32'h7fff_ffff) % `BOX_CHANNELS);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // drivers and waits
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_table();
    exp_t e;
    foreach (tbl[i]) begin
      @(posedge clk);
      in_stb    <= tbl[i].stb;
      in_chan   <= tbl[i].chan;
      in_sample <= tbl[i].sample;
      if (tbl[i].stb && (tbl[i].chan < `BOX_CHANNELS)) begin
        e.chan = tbl[i].chan;
        e.sum  = tbl[i].exp_sum;
        // driven now, sampled next edge, then 3 pipeline stages
        e.due  = cyc + 4;
        exp_q.push_back(e);
      end
    end
    @(posedge clk);
    in_stb <= 1'b0;
    tbl.delete();
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_q.size() > 0) && (n < 100)) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() > 0) begin
      err_cnt++;
      $display("timeout: %0d expected outputs never arrived", exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic do_reset();
    reset  <= 1'b1;
    in_stb <= 1'b0;
    @(posedge clk);
    // whatever was still in the pipeline is lost once reset is sampled
    exp_q.delete();
    @(negedge clk);
    // strobes must be quiet as soon as reset takes hold
    check_flag("out_stb", 1'b0, out_stb);
    for (int n = 1; n < 4; n++) begin
      @(posedge clk);
    end
    reset <= 1'b0;
    model_clear();
  endtask

  task automatic end_test(string name);
    test_cnt++;
    $display("test %s %s (%0d errors)", name,
             (err_cnt == err_base) ? "ok" : "bad", err_cnt - err_base);
    err_base = err_cnt;
  endtask

  // output monitor, sampled mid-cycle where outputs are settled
  always @(negedge clk) begin
    if (out_stb === 1'b1) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("output strobe at %0t with no sample pending", $time);
      end else begin
        chk_cnt++;
        if (exp_q[0].due != cyc) begin
          err_cnt++;
          $display("ERR %0t out_stb cycle exp=%0d act=%0d", $time, exp_q[0].due, cyc);
        end
        check_chan("out_chan", exp_q[0].chan, out_chan);
        check_sum("out_sum", exp_q[0].sum, out_sum);
        void'(exp_q.pop_front());
      end
    end else if ((exp_q.size() > 0) && (exp_q[0].due == cyc)) begin
      // missed strobe, drop it so later checks stay aligned
      check_flag("out_stb", 1'b1, out_stb);
      void'(exp_q.pop_front());
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    do_reset();

    // fill phase, delay line still holds power-up junk
    for (int i = 0; i < `BOX_WINDOW + 4; i++) begin
      add_row(1'b1, chan_t'(2), sample_t'($random(seed)));
    end
    run_table();
    wait_drain();
    end_test("fill");

    // long run on one channel with random idle cycles
    for (int i = 0; i < 200; i++) begin
      add_row(($random(seed) & 3) != 0, chan_t'(1), sample_t'($random(seed)));
    end
    run_table();
    wait_drain();
    end_test("steady");

    // full-rate, random channel every cycle
    for (int i = 0; i < 300; i++) begin
      add_row(1'b1, rand_chan(), sample_t'($random(seed)));
    end
    run_table();
    wait_drain();
    end_test("interleave");

    // gap pattern, monitor checks every strobe lands on its cycle
    for (int i = 0; i < 66; i++) begin
      add_row((i % 11) inside {0, 3, 4, 6, 10}, chan_t'((i % 2) * 3),
              sample_t'($random(seed)));
    end
    run_table();
    wait_drain();
    end_test("latency");

    // second reset hits while sums are still in flight
    for (int i = 0; i < 6; i++) begin
      add_row(1'b1, rand_chan(), sample_t'($random(seed)));
    end
    run_table();
    do_reset();
    // then every channel refills from empty
    for (int i = 0; i < `BOX_WINDOW + 2; i++) begin
      for (int c = 0; c < `BOX_CHANNELS; c++) begin
        add_row(1'b1, chan_t'(c), sample_t'($random(seed)));
      end
    end
    run_table();
    wait_drain();
    end_test("reset");

    // all ones, largest possible sum
    for (int i = 0; i < 2 * `BOX_WINDOW; i++) begin
      for (int c = 0; c < `BOX_CHANNELS; c++) begin
        add_row(1'b1, chan_t'(c), '1);
      end
    end
    run_table();
    wait_drain();
    end_test("max");

    $display("tests=%0d checks=%0d errors=%0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+common
common/boxcar_pkg.sv
common/lane_if.sv
boxcar/shift_reg.sv
boxcar/boxcar_lane.sv
verilog/lane_distributor.sv
verilog/lane_collector.sv
verilog/boxcar_bank.sv
test/tb_boxcar_bank.sv
